// ==== src/tx_status_pkg.sv ====
// Shared widths, field positions, queue sizing and register constants for the tx status path.
package tx_status_pkg;

    // field widths of one status record.
    localparam int CW_W     = 4;  // contention window.
    localparam int PRIO_W   = 2;  // linux priority.
    localparam int QIDX_W   = 2;  // hardware queue index.
    localparam int SN_W     = 10; // packet sequence number.
    localparam int STATUS_W = 5;  // attempt status.

    // total record width with cw in the top bits and status at the bottom.
    localparam int REC_W = CW_W + PRIO_W + QIDX_W + SN_W + STATUS_W;

    // least significant bit of each field inside the record.
    localparam int STATUS_LSB = 0;
    localparam int SN_LSB     = STATUS_LSB + STATUS_W;
    localparam int QIDX_LSB   = SN_LSB + SN_W;
    localparam int PRIO_LSB   = QIDX_LSB + QIDX_W;
    localparam int CW_LSB     = PRIO_LSB + PRIO_W;

    // the contention window is sampled this many cycles late.
    localparam int CW_DELAY = 5;

    // status queue sizing.
    localparam int QUEUE_DEPTH = 64;
    localparam int QUEUE_AW    = $clog2(QUEUE_DEPTH);
    localparam int COUNT_W     = QUEUE_AW + 1; // level runs from 0 up to QUEUE_DEPTH.

    // register read side.
    localparam int ADDR_W = 5;
    localparam logic [ADDR_W-1:0] STATUS_REG_ADDR = 5'h16; // word address of the status pop.

    // read data returned while no record is waiting.
    localparam logic [REC_W-1:0] EMPTY_MARK = {REC_W{1'b1}};

endpackage

// ==== src/tx_status_wr_if.sv ====
// Record write channel from the capture stage into the status queue; bind src and dst modports.
`timescale 1ns/1ps

interface tx_status_wr_if import tx_status_pkg::*; ();

    logic             wr;   // one cycle write strobe.
    logic [REC_W-1:0] rec;  // record to be stored.
    logic             full; // queue is at its depth and drops writes.

    // the producer side, the full level is offered but not required.
    modport src (
        output wr,
        output rec,
        input  full
    );

    // the queue side decides whether a write is taken.
    modport dst (
        input  wr,
        input  rec,
        output full
    );

endinterface

// ==== src/tx_status_capture.sv ====
// Capture stage that turns a completion strobe into a status record write for the queue.
`timescale 1ns/1ps

module tx_status_capture import tx_status_pkg::*; (
    input  logic                clk,
    input  logic                rstn,
    input  logic                tx_try_complete,
    input  logic [CW_W-1:0]     cw,
    input  logic [PRIO_W-1:0]   linux_prio,
    input  logic [QIDX_W-1:0]   tx_queue_idx,
    input  logic [SN_W-1:0]     tx_pkt_sn,
    input  logic [STATUS_W-1:0] tx_status,
    tx_status_wr_if.src         wr_port
);

    logic              complete_q;          // completion strobe, one cycle late.
    logic [CW_W-1:0]   cw_pipe [CW_DELAY];  // contention window history.
    logic [REC_W-1:0]  rec_word;

    // The strobe is registered so that the write lands one cycle after the attempt ends.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            complete_q <= 1'b0;
        end else begin
            complete_q <= tx_try_complete;
        end
    end

    // The delay line shifts every cycle whether or not an attempt is finishing.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < CW_DELAY; i++) begin
                cw_pipe[i] <= '0;
            end
        end else begin
            cw_pipe[0] <= cw; // first stage takes the live value.
            for (int i = 1; i < CW_DELAY; i++) begin
                cw_pipe[i] <= cw_pipe[i-1];
            end
        end
    end

    // Pack the record. Only cw is aged, the other fields are taken in the write cycle.
    always_comb begin
        rec_word = '0;
        rec_word[CW_LSB     +: CW_W]     = cw_pipe[CW_DELAY-1]; // cw from five cycles back.
        rec_word[PRIO_LSB   +: PRIO_W]   = linux_prio;
        rec_word[QIDX_LSB   +: QIDX_W]   = tx_queue_idx;
        rec_word[SN_LSB     +: SN_W]     = tx_pkt_sn;
        rec_word[STATUS_LSB +: STATUS_W] = tx_status;
    end

    assign wr_port.wr  = complete_q; // the queue itself drops the write when full.
    assign wr_port.rec = rec_word;

endmodule

// ==== src/status_queue.sv ====
// Single clock first-word-fall-through queue that stores status records until the host pops them.
`timescale 1ns/1ps

module status_queue import tx_status_pkg::*; (
    input  logic               clk,
    input  logic               rstn,
    tx_status_wr_if.dst        wr_port,
    input  logic               pop,
    output logic [REC_W-1:0]   head,
    output logic               empty,
    output logic [COUNT_W-1:0] count
);

    logic [REC_W-1:0]    mem [QUEUE_DEPTH]; // record storage.
    logic [QUEUE_AW-1:0] wr_ptr;            // next slot to fill.
    logic [QUEUE_AW-1:0] rd_ptr;            // oldest stored record.
    logic [COUNT_W-1:0]  level;             // number of stored records.
    logic                full;
    logic                do_wr;
    logic                do_rd;

    assign full  = (level == COUNT_W'(QUEUE_DEPTH));
    assign empty = (level == '0);

    // A write into a full queue is lost, a pop of an empty queue does nothing.
    assign do_wr = wr_port.wr && !full;
    assign do_rd = pop && !empty;

    // Each accepted record goes into the slot under the write pointer.
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_port.rec;
        end
    end

    // Pointers wrap on their own because the depth is a power of two.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
        end else if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_ptr <= '0;
        end else if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // A write and a pop in the same cycle leave the level unchanged.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            level <= '0;
        end else begin
            case ({do_wr, do_rd})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // Fall through, so the oldest record is visible as soon as it is written.
    assign head  = mem[rd_ptr];
    assign count = level;

    assign wr_port.full = full;

endmodule

// ==== src/tx_status_readout.sv ====
// Register read side that pops the status queue on a read of the status word address.
`timescale 1ns/1ps

module tx_status_readout import tx_status_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    input  logic              slv_reg_rden,
    input  logic [ADDR_W-1:0] axi_araddr_core,
    input  logic [REC_W-1:0]  head,
    input  logic              empty,
    output logic              pop,
    output logic [REC_W-1:0]  tx_status_out
);

    logic addr_hit; // the read targets the status word.
    logic empty_q;  // queue empty flag, one cycle late.

    assign addr_hit = (axi_araddr_core == STATUS_REG_ADDR);

    // Every read strobe at the status address pops one record.
    assign pop = slv_reg_rden && addr_hit;

    // Reset starts out as empty so that the first reads return the marker.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            empty_q <= 1'b1;
        end else begin
            empty_q <= empty;
        end
    end

    // The marker follows the registered flag, so it trails the queue by a cycle.
    assign tx_status_out = empty_q ? EMPTY_MARK : head;

endmodule

// ==== src/tx_status_top.sv ====
// Top level of the tx status path, joining capture, queue and register readout.
`timescale 1ns/1ps

module tx_status_top import tx_status_pkg::*; (
    input  logic                clk,
    input  logic                rstn,
    input  logic                tx_try_complete,
    input  logic [CW_W-1:0]     cw,
    input  logic [STATUS_W-1:0] tx_status,
    input  logic [PRIO_W-1:0]   linux_prio,
    input  logic [QIDX_W-1:0]   tx_queue_idx,
    input  logic [SN_W-1:0]     tx_pkt_sn,
    input  logic                slv_reg_rden,
    input  logic [ADDR_W-1:0]   axi_araddr_core,
    output logic [REC_W-1:0]    tx_status_out,
    output logic [COUNT_W-1:0]  status_count,
    output logic                status_full
);

    logic [REC_W-1:0] q_head;  // oldest record in the queue.
    logic             q_empty;
    logic             q_pop;

    tx_status_wr_if wr_if ();

    tx_status_capture u_capture (
        .clk             (clk),
        .rstn            (rstn),
        .tx_try_complete (tx_try_complete),
        .cw              (cw),
        .linux_prio      (linux_prio),
        .tx_queue_idx    (tx_queue_idx),
        .tx_pkt_sn       (tx_pkt_sn),
        .tx_status       (tx_status),
        .wr_port         (wr_if.src)
    );

    status_queue u_queue (
        .clk     (clk),
        .rstn    (rstn),
        .wr_port (wr_if.dst),
        .pop     (q_pop),
        .head    (q_head),
        .empty   (q_empty),
        .count   (status_count)
    );

    tx_status_readout u_readout (
        .clk             (clk),
        .rstn            (rstn),
        .slv_reg_rden    (slv_reg_rden),
        .axi_araddr_core (axi_araddr_core),
        .head            (q_head),
        .empty           (q_empty),
        .pop             (q_pop),
        .tx_status_out   (tx_status_out)
    );

    // The full level comes straight from the queue side of the write channel.
    assign status_full = wr_if.full;

endmodule

// ==== test/tx_status_checker.sv ====
// Reference model and scoreboard for the tx status path; instantiate beside the DUT on the same ports.
`timescale 1ns/1ps

module tx_status_checker import tx_status_pkg::*; (
    input  logic                clk,
    input  logic                rstn,
    input  logic                tx_try_complete,
    input  logic [CW_W-1:0]     cw,
    input  logic [STATUS_W-1:0] tx_status,
    input  logic [PRIO_W-1:0]   linux_prio,
    input  logic [QIDX_W-1:0]   tx_queue_idx,
    input  logic [SN_W-1:0]     tx_pkt_sn,
    input  logic                slv_reg_rden,
    input  logic [ADDR_W-1:0]   axi_araddr_core,
    input  logic [REC_W-1:0]    tx_status_out,
    input  logic [COUNT_W-1:0]  status_count,
    input  logic                status_full,
    output int                  error_count,
    output int                  check_count,
    output int                  drop_count,
    output int                  pop_count
);

    logic [CW_W-1:0]  cw_hist [CW_DELAY+1]; // entry 0 is the newest cw, the last one is the oldest.
    logic             comp_q;               // completion seen in the previous cycle.
    logic             empty_prev;           // model queue was empty in the previous cycle.
    logic [REC_W-1:0] model_q [$];          // records in write order.
    int               errors = 0;
    int               checks = 0;
    int               drops  = 0;
    int               pops   = 0;

    assign error_count = errors;
    assign check_count = checks;
    assign drop_count  = drops;
    assign pop_count   = pops;

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0d ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // Inputs and outputs are sampled before the edge updates them, so each step sees one cycle.
    always @(posedge clk) begin : model_step
        logic [REC_W-1:0] new_rec;
        logic             do_wr;
        logic             do_rd;
        if (!rstn) begin
            for (int i = 0; i <= CW_DELAY; i++) begin
                cw_hist[i] = '0; // the delay line is cleared by reset.
            end
            comp_q     = 1'b0;
            empty_prev = 1'b1;
            model_q.delete();
        end else begin
            compare_value("status_count", 32'(status_count), 32'(model_q.size()));
            compare_value("status_full", 32'(status_full), 32'(model_q.size() == QUEUE_DEPTH));
            if (empty_prev) begin
                compare_value("tx_status_out (empty)", 32'(tx_status_out), 32'(EMPTY_MARK));
            end else if (model_q.size() > 0) begin
                compare_value("tx_status_out (head)", 32'(tx_status_out), 32'(model_q[0]));
            end

            // age the cw history so the last entry holds the value from five cycles back.
            for (int i = CW_DELAY; i > 0; i--) begin
                cw_hist[i] = cw_hist[i-1];
            end
            cw_hist[0] = cw;

            new_rec = {cw_hist[CW_DELAY], linux_prio, tx_queue_idx, tx_pkt_sn, tx_status};
            do_wr   = comp_q && (model_q.size() < QUEUE_DEPTH);
            do_rd   = slv_reg_rden && (axi_araddr_core == STATUS_REG_ADDR)
                      && (model_q.size() != 0);

            if (comp_q && !do_wr) begin
                drops++; // completion lost to a full queue.
            end
            if (do_rd && !empty_prev) begin
                pops++; // this popped record was visible on the read data.
            end

            empty_prev = (model_q.size() == 0);
            if (do_rd) begin
                void'(model_q.pop_front());
            end
            if (do_wr) begin
                model_q.push_back(new_rec);
            end
            comp_q = tx_try_complete;
        end
    end

endmodule

// ==== test/tb_tx_status.sv ====
// Testbench top for the tx status path; drives random traffic in phases and reports the result.
`timescale 1ns/1ps

module tb_tx_status import tx_status_pkg::*; ();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;
    localparam int FILL_CYCLES  = 400;  // write heavy, overflows the queue.
    localparam int DRAIN_CYCLES = 400;  // read heavy, drains and reads while empty.
    localparam int MIXED_CYCLES = 800;
    localparam int TAIL_CYCLES  = 20;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + FILL_CYCLES + DRAIN_CYCLES
                                     + MIXED_CYCLES + TAIL_CYCLES + 200;

    logic                clk;
    logic                rstn;
    logic                tx_try_complete;
    logic [CW_W-1:0]     cw;
    logic [STATUS_W-1:0] tx_status;
    logic [PRIO_W-1:0]   linux_prio;
    logic [QIDX_W-1:0]   tx_queue_idx;
    logic [SN_W-1:0]     tx_pkt_sn;
    logic                slv_reg_rden;
    logic [ADDR_W-1:0]   axi_araddr_core;
    logic [REC_W-1:0]    tx_status_out;
    logic [COUNT_W-1:0]  status_count;
    logic                status_full;
    int                  error_count;
    int                  check_count;
    int                  drop_count;
    int                  pop_count;

    tx_status_top dut0 (.*);

    tx_status_checker chk0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Each loop pass is one cycle in which every input takes a fresh random value.
    task automatic drive_phase(input int cycles, input int comp_pct, input int rd_pct,
                               input int hit_pct);
        logic [ADDR_W-1:0] addr;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            addr = ADDR_W'($urandom);
            if (addr == STATUS_REG_ADDR) begin
                addr = addr ^ ADDR_W'(1); // a miss must really miss.
            end
            if (($urandom % 100) < hit_pct) begin
                addr = STATUS_REG_ADDR;
            end
            tx_try_complete <= (($urandom % 100) < comp_pct);
            cw              <= CW_W'($urandom);
            tx_status       <= STATUS_W'($urandom);
            linux_prio      <= PRIO_W'($urandom);
            tx_queue_idx    <= QIDX_W'($urandom);
            tx_pkt_sn       <= SN_W'($urandom);
            slv_reg_rden    <= (($urandom % 100) < rd_pct);
            axi_araddr_core <= addr;
        end
    endtask

    initial begin
        void'($urandom(32'hdc6a9802));
        clk             = 1'b0;
        rstn            = 1'b0;
        tx_try_complete = 1'b0;
        cw              = '0;
        tx_status       = '0;
        linux_prio      = '0;
        tx_queue_idx    = '0;
        tx_pkt_sn       = '0;
        slv_reg_rden    = 1'b0;
        axi_araddr_core = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;

        drive_phase(FILL_CYCLES, 80, 30, 15);
        drive_phase(DRAIN_CYCLES, 5, 70, 60);
        drive_phase(MIXED_CYCLES, 35, 40, 50);
        drive_phase(TAIL_CYCLES, 0, 0, 0);

        @(posedge clk);
        #1;
        $display("errors %0d, checks %0d, dropped %0d, checked pops %0d",
                 error_count, check_count, drop_count, pop_count);
        if (drop_count == 0) begin
            $display("the queue never overflowed, so dropped writes were not exercised");
        end
        if (pop_count == 0) begin
            $display("no popped record reached the read data, so read order was not exercised");
        end
        if (error_count == 0 && drop_count > 0 && pop_count > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog sized from the phase lengths plus a margin.
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout after %0d cycles, the run did not reach its end", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== verilog.f ====
src/tx_status_pkg.sv
src/tx_status_wr_if.sv
src/tx_status_capture.sv
src/status_queue.sv
src/tx_status_readout.sv
src/tx_status_top.sv
test/tx_status_checker.sv
test/tb_tx_status.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_tx_status
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only when the pass line appears in the output.
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
